/* all.f */
logic/csc_pkg.sv
logic/csc_apb_regs.sv
logic/csc_sequencer.sv
logic/chroma_upsampler.sv
logic/rgb_matrix.sv
logic/csc_top.sv
verif/csc_mem_model.sv
verif/csc_tb.sv

/* logic/chroma_upsampler.sv */
// Six-tap chroma interpolation for U and V; outputs follow the window by one cycle
`timescale 1ns/1ns

module chroma_upsampler (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic row_load,
	input logic push,
	input csc_pkg::pix_t u_in,
	input csc_pkg::pix_t v_in,
	output csc_pkg::pix_t u_even,
	output csc_pkg::pix_t u_odd,
	output csc_pkg::pix_t v_even,
	output csc_pkg::pix_t v_odd
);

	// Channel 0 is U, channel 1 is V; tap 0 oldest, tap 5 newest
	logic [1:0][5:0][7:0] win;
	logic [1:0][7:0] smp_in;
	logic [1:0][7:0] even_q;
	logic [1:0][7:0] odd_q;

	// Odd pixel sits between taps 2 and 3
	function automatic csc_pkg::pix_t fir_odd(input logic [5:0][7:0] w);
		int s21, s52, s159;
		int acc;
		s21 = int'(w[0]) + int'(w[5]); // Symmetric pairs
		s52 = int'(w[1]) + int'(w[4]);
		s159 = int'(w[2]) + int'(w[3]);
		acc = csc_pkg::TAP_21 * s21 - csc_pkg::TAP_52 * s52
			+ csc_pkg::TAP_159 * s159 + csc_pkg::FIR_ROUND;
		return csc_pkg::clip_pix(acc >>> csc_pkg::FIR_SHIFT);
	endfunction

	assign smp_in = {v_in, u_in};

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			win <= '0;
			even_q <= '0;
			odd_q <= '0;
		end else begin
			for (int ch = 0; ch < 2; ch++) begin
				if (row_load) begin
					win[ch] <= {6{smp_in[ch]}}; // Left edge replication
				end else if (push) begin
					win[ch] <= {smp_in[ch], win[ch][5:1]};
				end
				even_q[ch] <= win[ch][2];
				odd_q[ch] <= fir_odd(win[ch]);
			end
		end
	end

	assign u_even = even_q[0];
	assign u_odd = odd_q[0];
	assign v_even = even_q[1];
	assign v_odd = odd_q[1];

endmodule

/* logic/csc_apb_regs.sv */
// APB slave with zero wait states; only word offsets 0x0, 0x4 and 0x8 are decoded
`timescale 1ns/1ns

module csc_apb_regs #(
	parameter int TOTAL_PAIRS = 38400
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input csc_pkg::apb_req_t apb_req,
	output csc_pkg::apb_rsp_t apb_rsp,
	input logic run_end,
	input logic pair_written,
	output logic start,
	output logic busy
);

	logic access;
	logic wr_ctrl;
	logic accept;
	logic done;
	logic [31:0] pair_cnt;
	csc_pkg::csc_status_t status;

	assign access = apb_req.psel && apb_req.penable; // Access phase
	assign wr_ctrl = access && apb_req.pwrite && (apb_req.paddr == csc_pkg::REG_CTRL);
	assign accept = wr_ctrl && apb_req.pwdata[0] && !busy;
	assign status = '{done: done, busy: busy};

	always_comb begin
		apb_rsp = '0;
		apb_rsp.pready = 1'b1;
		case (apb_req.paddr)
			csc_pkg::REG_CTRL: apb_rsp.prdata = '0; // Start bit self-clears
			csc_pkg::REG_STATUS: begin
				apb_rsp.prdata = 32'(status);
				apb_rsp.pslverr = access && apb_req.pwrite; // Read only
			end
			csc_pkg::REG_PAIRS: begin
				apb_rsp.prdata = pair_cnt;
				apb_rsp.pslverr = access && apb_req.pwrite;
			end
			default: apb_rsp.pslverr = access;
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			pair_cnt <= '0;
		end else begin
			start <= accept; // One cycle pulse
			if (accept) begin
				busy <= 1'b1;
				done <= 1'b0;
				pair_cnt <= '0;
			end else begin
				if (run_end) begin
					busy <= 1'b0;
					done <= 1'b1; // Sticky until next start
				end
				if (pair_written) pair_cnt <= pair_cnt + 32'd1;
			end
		end
	end

	// Access phase must follow a setup phase with psel held
	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		$rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel));

	// Sequencer never reports more pairs than the image holds
	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		pair_cnt <= 32'(TOTAL_PAIRS));

endmodule

/* logic/csc_pkg.sv */
// Shared widths, bus structs, enums and fixed-point constants; image size is set per instance
package csc_pkg;

	localparam int ADDR_W = 18; // Word address into the image memory
	localparam int DATA_W = 16;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] mem_word_t;
	typedef logic [7:0] pix_t; // One sample or colour component

	typedef struct packed {
		logic en;
		logic we;
		addr_t addr;
		mem_word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef struct packed {
		pix_t y_even;
		pix_t y_odd;
		pix_t u_even;
		pix_t u_odd;
		pix_t v_even;
		pix_t v_odd;
	} yuv_pair_t;

	// Word0 {R0,G0}, word1 {B0,R1}, word2 {G1,B1}
	typedef struct packed {
		mem_word_t word0;
		mem_word_t word1;
		mem_word_t word2;
	} rgb_pair_t;

	// Member order matches the STATUS bits, busy in bit 0
	typedef struct packed {
		logic done;
		logic busy;
	} csc_status_t;

	typedef enum logic [2:0] {S_IDLE, S_Y, S_CHROMA, S_MAT, S_WR} seq_state_e;

	typedef enum logic [7:0] {
		REG_CTRL   = 8'h00,
		REG_STATUS = 8'h04,
		REG_PAIRS  = 8'h08
	} apb_reg_e;

	// Chroma interpolation taps, gain of 256
	localparam int TAP_21 = 21;
	localparam int TAP_52 = 52;
	localparam int TAP_159 = 159;
	localparam int FIR_ROUND = 128;
	localparam int FIR_SHIFT = 8;

	// YUV to RGB matrix, Q16
	localparam int C_Y = 76284;
	localparam int C_RV = 104595;
	localparam int C_GU = 25624;
	localparam int C_GV = 53281;
	localparam int C_BU = 132251;
	localparam int MAT_SHIFT = 16;

	localparam int Y_OFS = 16;
	localparam int C_OFS = 128;

	// Saturate to one unsigned byte
	function automatic pix_t clip_pix(input int v);
		pix_t r;
		if (v < 0) r = '0;
		else if (v > 255) r = '1;
		else r = v[7:0];
		return r;
	endfunction

endpackage

/* logic/csc_sequencer.sv */
// Serialises all memory traffic, one pixel pair at a time; assumes exactly two-cycle read data
`timescale 1ns/1ns

module csc_sequencer #(
	parameter int ROW_PIXELS = 320,
	parameter int ROWS = 240
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	output csc_pkg::mem_req_t mem_req,
	input csc_pkg::mem_word_t mem_rdata,
	output logic row_load,
	output logic push,
	output csc_pkg::pix_t u_in,
	output csc_pkg::pix_t v_in,
	input csc_pkg::pix_t u_even,
	input csc_pkg::pix_t u_odd,
	input csc_pkg::pix_t v_even,
	input csc_pkg::pix_t v_odd,
	output csc_pkg::yuv_pair_t pair_in,
	output logic pair_valid,
	input csc_pkg::rgb_pair_t rgb_out,
	input logic rgb_valid,
	output logic pair_written,
	output logic run_end
);

	typedef logic [15:0] cnt_t;

	localparam int PAIRS_ROW = ROW_PIXELS / 2; // Also the chroma samples per row
	localparam int U_BASE = ROW_PIXELS * ROWS / 2;
	localparam int V_BASE = U_BASE + ROW_PIXELS * ROWS / 4;
	localparam int RGB_BASE = V_BASE + ROW_PIXELS * ROWS / 4;

	csc_pkg::seq_state_e state;
	logic [2:0] step;
	logic priming; // Filling the window at row start
	cnt_t samp; // Index of the next chroma sample to enter the window
	cnt_t pair_cnt, row_cnt;
	csc_pkg::addr_t y_addr, u_addr, v_addr, rgb_addr;
	csc_pkg::mem_word_t y_word, u_word, v_word;
	csc_pkg::rgb_pair_t rgb_hold;
	logic shift_en;
	logic need;

	assign shift_en = priming || (pair_cnt != '0); // Pair 0 uses the primed window
	// Even sample inside the row means a fresh word, else reuse the held low byte
	assign need = shift_en && !samp[0] && (samp < cnt_t'(PAIRS_ROW));

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= csc_pkg::S_IDLE;
			step <= '0;
			priming <= 1'b0;
			samp <= '0;
			pair_cnt <= '0;
			row_cnt <= '0;
			y_addr <= '0;
			u_addr <= '0;
			v_addr <= '0;
			rgb_addr <= '0;
			mem_req <= '0;
			row_load <= 1'b0;
			push <= 1'b0;
			pair_valid <= 1'b0;
			pair_written <= 1'b0;
			run_end <= 1'b0;
		end else begin
			mem_req.en <= 1'b0;
			row_load <= 1'b0;
			push <= 1'b0;
			pair_valid <= 1'b0;
			pair_written <= 1'b0;
			run_end <= 1'b0;
			case (state)
				csc_pkg::S_IDLE: if (start) begin
					y_addr <= '0;
					u_addr <= csc_pkg::addr_t'(U_BASE);
					v_addr <= csc_pkg::addr_t'(V_BASE);
					rgb_addr <= csc_pkg::addr_t'(RGB_BASE);
					row_cnt <= '0;
					pair_cnt <= '0;
					samp <= '0;
					priming <= 1'b1;
					step <= '0;
					state <= csc_pkg::S_CHROMA;
				end
				csc_pkg::S_Y: begin
					mem_req <= '{en: 1'b1, we: 1'b0, addr: y_addr, wdata: '0};
					step <= '0;
					state <= csc_pkg::S_CHROMA;
				end
				csc_pkg::S_CHROMA: begin
					step <= step + 3'd1;
					case (step)
						3'd0: if (need) mem_req <= '{en: 1'b1, we: 1'b0, addr: u_addr, wdata: '0};
						3'd1: if (need) mem_req <= '{en: 1'b1, we: 1'b0, addr: v_addr, wdata: '0};
						3'd4: begin // V word on the bus now
							row_load <= priming && (samp == '0);
							push <= shift_en && !(priming && (samp == '0));
							if (shift_en) samp <= samp + cnt_t'(1);
							if (need) begin
								u_addr <= u_addr + csc_pkg::addr_t'(1);
								v_addr <= v_addr + csc_pkg::addr_t'(1);
							end
							if (priming && (samp == cnt_t'(3))) begin
								priming <= 1'b0;
								state <= csc_pkg::S_Y;
							end else if (priming) begin
								step <= '0;
							end
						end
						3'd6: begin // Upsampler outputs settle next cycle
							step <= '0;
							state <= csc_pkg::S_MAT;
						end
						default: ;
					endcase
				end
				csc_pkg::S_MAT: begin
					if (step == '0) begin
						pair_valid <= 1'b1;
						step <= 3'd1;
					end else if (rgb_valid) begin
						mem_req <= '{en: 1'b1, we: 1'b1, addr: rgb_addr, wdata: rgb_out.word0};
						step <= '0;
						state <= csc_pkg::S_WR;
					end
				end
				csc_pkg::S_WR: begin
					step <= step + 3'd1;
					if (step == 3'd0) begin
						mem_req <= '{en: 1'b1, we: 1'b1, addr: rgb_addr + csc_pkg::addr_t'(1),
							wdata: rgb_hold.word1};
					end else if (step == 3'd1) begin
						mem_req <= '{en: 1'b1, we: 1'b1, addr: rgb_addr + csc_pkg::addr_t'(2),
							wdata: rgb_hold.word2};
						pair_written <= 1'b1;
					end else begin
						y_addr <= y_addr + csc_pkg::addr_t'(1);
						rgb_addr <= rgb_addr + csc_pkg::addr_t'(3);
						if (pair_cnt != cnt_t'(PAIRS_ROW - 1)) begin
							pair_cnt <= pair_cnt + cnt_t'(1);
							state <= csc_pkg::S_Y;
						end else if (row_cnt == cnt_t'(ROWS - 1)) begin
							run_end <= 1'b1;
							state <= csc_pkg::S_IDLE;
						end else begin // Chroma addresses already point at the next row
							row_cnt <= row_cnt + cnt_t'(1);
							pair_cnt <= '0;
							samp <= '0;
							priming <= 1'b1;
							step <= '0;
							state <= csc_pkg::S_CHROMA;
						end
					end
				end
				default: state <= csc_pkg::S_IDLE;
			endcase
		end
	end

	// Read data capture, no reset needed
	always_ff @(posedge CLOCK_50_I) begin
		if (state == csc_pkg::S_CHROMA) begin
			if (step == 3'd2 && !priming) y_word <= mem_rdata;
			if (step == 3'd3 && need) u_word <= mem_rdata;
			if (step == 3'd4) begin
				u_in <= need ? u_word[15:8] : u_word[7:0];
				v_in <= need ? mem_rdata[15:8] : v_word[7:0];
				if (need) v_word <= mem_rdata;
			end
		end
		if (state == csc_pkg::S_MAT && step == '0) begin
			pair_in <= '{y_even: y_word[15:8], y_odd: y_word[7:0], u_even: u_even,
				u_odd: u_odd, v_even: v_even, v_odd: v_odd};
		end
		if (state == csc_pkg::S_MAT && rgb_valid) rgb_hold <= rgb_out;
	end

	// Last write of a run must retire before the FSM reports idle
	assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(state == csc_pkg::S_IDLE) |-> !mem_req.en);

endmodule

/* logic/csc_top.sv */
// 4:2:2 YUV to RGB block converter; ROW_PIXELS must be a multiple of 4 and at least 8
`timescale 1ns/1ns

module csc_top #(
	parameter int ROW_PIXELS = 320,
	parameter int ROWS = 240
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input csc_pkg::apb_req_t apb_req,
	output csc_pkg::apb_rsp_t apb_rsp,
	output csc_pkg::mem_req_t mem_req,
	input csc_pkg::mem_word_t mem_rdata
);

	logic start;
	logic run_end;
	logic pair_written;
	logic row_load;
	logic push;
	csc_pkg::pix_t u_in, v_in;
	csc_pkg::pix_t u_even, u_odd, v_even, v_odd;
	csc_pkg::yuv_pair_t pair_in;
	logic pair_valid;
	csc_pkg::rgb_pair_t rgb_out;
	logic rgb_valid;

	csc_apb_regs #(
		.TOTAL_PAIRS(ROW_PIXELS * ROWS / 2)
	) u_regs (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.run_end(run_end),
		.pair_written(pair_written),
		.start(start),
		.busy() // Seen by software through STATUS
	);

	csc_sequencer #(
		.ROW_PIXELS(ROW_PIXELS),
		.ROWS(ROWS)
	) u_seq (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.start(start),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata),
		.row_load(row_load),
		.push(push),
		.u_in(u_in),
		.v_in(v_in),
		.u_even(u_even),
		.u_odd(u_odd),
		.v_even(v_even),
		.v_odd(v_odd),
		.pair_in(pair_in),
		.pair_valid(pair_valid),
		.rgb_out(rgb_out),
		.rgb_valid(rgb_valid),
		.pair_written(pair_written),
		.run_end(run_end)
	);

	chroma_upsampler u_ups (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.row_load(row_load),
		.push(push),
		.u_in(u_in),
		.v_in(v_in),
		.u_even(u_even),
		.u_odd(u_odd),
		.v_even(v_even),
		.v_odd(v_odd)
	);

	rgb_matrix u_mat (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.pair_in(pair_in),
		.pair_valid(pair_valid),
		.rgb_out(rgb_out),
		.rgb_valid(rgb_valid)
	);

endmodule

/* logic/rgb_matrix.sv */
// Three-stage YUV to RGB matrix for one pixel pair per cycle; output is packed three words
`timescale 1ns/1ns

module rgb_matrix (
	input logic CLOCK_50_I,
	input logic resetn,
	input csc_pkg::yuv_pair_t pair_in,
	input logic pair_valid,
	output csc_pkg::rgb_pair_t rgb_out,
	output logic rgb_valid
);

	logic [1:0][7:0] y_px, u_px, v_px; // Index 0 is the even pixel
	logic signed [9:0] y1 [2];
	logic signed [9:0] u1 [2];
	logic signed [9:0] v1 [2];
	int r2 [2];
	int g2 [2];
	int b2 [2];
	logic [1:0] vld;

	// Same rule for every component
	function automatic csc_pkg::pix_t to_pix(input int acc);
		return csc_pkg::clip_pix(acc >>> csc_pkg::MAT_SHIFT);
	endfunction

	assign y_px = {pair_in.y_odd, pair_in.y_even};
	assign u_px = {pair_in.u_odd, pair_in.u_even};
	assign v_px = {pair_in.v_odd, pair_in.v_even};

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			vld <= '0;
			rgb_valid <= 1'b0;
		end else begin
			vld <= {vld[0], pair_valid};
			rgb_valid <= vld[1];
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		for (int px = 0; px < 2; px++) begin
			// Stage 1
			y1[px] <= 10'(int'(y_px[px]) - csc_pkg::Y_OFS);
			u1[px] <= 10'(int'(u_px[px]) - csc_pkg::C_OFS);
			v1[px] <= 10'(int'(v_px[px]) - csc_pkg::C_OFS);
			// Stage 2, Q16 sums
			r2[px] <= csc_pkg::C_Y * int'(y1[px]) + csc_pkg::C_RV * int'(v1[px]);
			g2[px] <= csc_pkg::C_Y * int'(y1[px]) - csc_pkg::C_GU * int'(u1[px])
				- csc_pkg::C_GV * int'(v1[px]);
			b2[px] <= csc_pkg::C_Y * int'(y1[px]) + csc_pkg::C_BU * int'(u1[px]);
		end
		// Stage 3
		rgb_out.word0 <= {to_pix(r2[0]), to_pix(g2[0])};
		rgb_out.word1 <= {to_pix(b2[0]), to_pix(r2[1])};
		rgb_out.word2 <= {to_pix(g2[1]), to_pix(b2[1])};
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found on PATH"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module csc_tb -f all.f -o sim_csc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_csc 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* verif/csc_mem_model.sv */
// Word memory with two-cycle read data and no back-pressure; 64 words, upper address bits ignored
`timescale 1ns/1ns

module csc_mem_model #(
	parameter int DEPTH = 64
) (
	input logic CLOCK_50_I,
	input logic resetn,
	input csc_pkg::mem_req_t mem_req,
	output csc_pkg::mem_word_t mem_rdata
);

	localparam int AW = $clog2(DEPTH);

	csc_pkg::mem_word_t mem [DEPTH];
	csc_pkg::mem_word_t rd_q; // First stage of the read pipe
	logic bd_en = 1'b0; // Backdoor write from the testbench
	logic [AW-1:0] bd_addr;
	csc_pkg::mem_word_t bd_data;

	always @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			rd_q <= '0;
			mem_rdata <= '0;
		end else begin
			if (mem_req.en && !mem_req.we) rd_q <= mem[mem_req.addr[AW-1:0]];
			mem_rdata <= rd_q; // Second cycle
		end
	end

	// DUT writes win over the backdoor
	always @(posedge CLOCK_50_I) begin
		if (mem_req.en && mem_req.we) mem[mem_req.addr[AW-1:0]] <= mem_req.wdata;
		else if (bd_en) mem[bd_addr] <= bd_data;
	end

	task automatic preload(input csc_pkg::addr_t addr, input csc_pkg::mem_word_t data);
		@(posedge CLOCK_50_I);
		#1;
		bd_en = 1'b1;
		bd_addr = addr[AW-1:0];
		bd_data = data;
		@(posedge CLOCK_50_I);
		#1;
		bd_en = 1'b0;
	endtask

	task automatic peek(input csc_pkg::addr_t addr, output csc_pkg::mem_word_t data);
		data = mem[addr[AW-1:0]];
	endtask

endmodule

/* verif/csc_tb.sv */
// Directed tests on an 8x2 image; expected RGB comes from an integer model of the conversion rules
`timescale 1ns/1ns

module csc_tb;

	localparam int ROW_PIXELS = 8;
	localparam int ROWS = 2;
	localparam int HALF = ROW_PIXELS / 2; // Pairs per row, also chroma samples per row
	localparam int PAIRS = ROW_PIXELS * ROWS / 2;
	localparam int U_BASE = PAIRS;
	localparam int V_BASE = U_BASE + PAIRS / 2;
	localparam int RGB_BASE = V_BASE + PAIRS / 2;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS = 5;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 * PAIRS + 600; // Margin covers preloads

	logic CLOCK_50_I;
	logic resetn;
	csc_pkg::apb_req_t apb_req;
	csc_pkg::apb_rsp_t apb_rsp;
	csc_pkg::mem_req_t mem_req;
	csc_pkg::mem_word_t mem_rdata;
	logic [31:0] lfsr;
	csc_pkg::pix_t y_img [ROWS][ROW_PIXELS];
	csc_pkg::pix_t u_img [ROWS][HALF];
	csc_pkg::pix_t v_img [ROWS][HALF];

	csc_top #(.ROW_PIXELS(ROW_PIXELS), .ROWS(ROWS)) u_dut (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata)
	);

	csc_mem_model u_mem (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata)
	);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		fail_now();
	end

	task automatic fail_now();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic csc_pkg::pix_t rand_pix();
		csc_pkg::pix_t p;
		for (int i = 0; i < 8; i++) p = {p[6:0], lfsr_step()};
		return p;
	endfunction

	function automatic int clip255(input int v);
		if (v < 0) return 0;
		if (v > 255) return 255;
		return v;
	endfunction

	// Chroma sample with edge replication at both row ends
	function automatic int chroma_at(input bit is_v, input int r, input int j);
		int jc;
		jc = (j < 0) ? 0 : ((j > HALF - 1) ? HALF - 1 : j);
		return is_v ? int'(v_img[r][jc]) : int'(u_img[r][jc]);
	endfunction

	function automatic int chroma_odd(input bit is_v, input int r, input int k);
		int acc;
		acc = 21 * (chroma_at(is_v, r, k - 2) + chroma_at(is_v, r, k + 3))
			- 52 * (chroma_at(is_v, r, k - 1) + chroma_at(is_v, r, k + 2))
			+ 159 * (chroma_at(is_v, r, k) + chroma_at(is_v, r, k + 1)) + 128;
		return clip255(acc >>> 8);
	endfunction

	// Returns {R, G, B}
	function automatic logic [23:0] pixel_rgb(input int y, input int u, input int v);
		int r, g, b;
		r = (76284 * (y - 16) + 104595 * (v - 128)) >>> 16;
		g = (76284 * (y - 16) - 25624 * (u - 128) - 53281 * (v - 128)) >>> 16;
		b = (76284 * (y - 16) + 132251 * (u - 128)) >>> 16;
		return {8'(clip255(r)), 8'(clip255(g)), 8'(clip255(b))};
	endfunction

	function automatic csc_pkg::rgb_pair_t expected_pair(input int r, input int k);
		logic [23:0] p0, p1;
		p0 = pixel_rgb(int'(y_img[r][2*k]), int'(u_img[r][k]), int'(v_img[r][k]));
		p1 = pixel_rgb(int'(y_img[r][2*k+1]), chroma_odd(1'b0, r, k), chroma_odd(1'b1, r, k));
		return {p0[23:8], p0[7:0], p1[23:16], p1[15:0]};
	endfunction

	function automatic csc_pkg::apb_rsp_t make_rsp(input logic [31:0] prdata, input logic err);
		csc_pkg::apb_rsp_t rsp;
		rsp.prdata = prdata;
		rsp.pready = 1'b1;
		rsp.pslverr = err;
		return rsp;
	endfunction

	task automatic check_word(input string name, input csc_pkg::mem_word_t exp,
		input csc_pkg::mem_word_t act);
		if (act !== exp) begin
			$display("Error %s: expected 0x%04h, actual 0x%04h", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_status(input string name, input csc_pkg::csc_status_t exp,
		input csc_pkg::csc_status_t act);
		if (act !== exp) begin
			$display("Error %s: expected busy %0b done %0b, actual busy %0b done %0b",
				name, exp.busy, exp.done, act.busy, act.done);
			fail_now();
		end
	endtask

	task automatic check_rsp(input string name, input csc_pkg::apb_rsp_t exp,
		input csc_pkg::apb_rsp_t act);
		if (act !== exp) begin
			$display("Error %s: expected prdata 0x%08h pready %0b pslverr %0b, actual 0x%08h %0b %0b",
				name, exp.prdata, exp.pready, exp.pslverr, act.prdata, act.pready, act.pslverr);
			fail_now();
		end
	endtask

	// Setup phase, then access phase; response sampled mid access
	task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data,
		output csc_pkg::apb_rsp_t rsp);
		@(posedge CLOCK_50_I);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
		@(posedge CLOCK_50_I);
		#1;
		apb_req.penable = 1'b1;
		@(negedge CLOCK_50_I);
		rsp = apb_rsp;
		@(posedge CLOCK_50_I);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		output csc_pkg::apb_rsp_t rsp);
		apb_access(1'b1, addr, data, rsp);
		rsp.prdata = '0; // No read value on a write
	endtask

	task automatic apb_read(input logic [7:0] addr, output csc_pkg::apb_rsp_t rsp);
		apb_access(1'b0, addr, 32'h0, rsp);
	endtask

	task automatic read_status(output csc_pkg::csc_status_t st);
		csc_pkg::apb_rsp_t rsp;
		apb_read(csc_pkg::REG_STATUS, rsp);
		st = rsp.prdata[1:0];
	endtask

	task automatic start_run(input string name);
		csc_pkg::apb_rsp_t rsp;
		apb_write(csc_pkg::REG_CTRL, 32'h1, rsp);
		check_rsp(name, make_rsp(32'h0, 1'b0), rsp);
	endtask

	task automatic wait_idle();
		csc_pkg::csc_status_t st;
		do begin
			read_status(st);
		end while (st.busy); // Bounded by the watchdog
	endtask

	task automatic load_image();
		for (int r = 0; r < ROWS; r++) begin
			for (int k = 0; k < HALF; k++)
				u_mem.preload(csc_pkg::addr_t'(r * HALF + k), {y_img[r][2*k], y_img[r][2*k+1]});
			for (int j = 0; j < HALF; j += 2) begin
				u_mem.preload(csc_pkg::addr_t'(U_BASE + (r * HALF + j) / 2),
					{u_img[r][j], u_img[r][j+1]});
				u_mem.preload(csc_pkg::addr_t'(V_BASE + (r * HALF + j) / 2),
					{v_img[r][j], v_img[r][j+1]});
			end
		end
		for (int a = RGB_BASE; a < RGB_BASE + 3 * PAIRS; a++)
			u_mem.preload(csc_pkg::addr_t'(a), 16'h0); // Clear old results
	endtask

	task automatic fill_image(input bit random, input csc_pkg::pix_t val);
		for (int r = 0; r < ROWS; r++) begin
			for (int x = 0; x < ROW_PIXELS; x++) y_img[r][x] = random ? rand_pix() : val;
			for (int k = 0; k < HALF; k++) begin
				u_img[r][k] = random ? rand_pix() : val;
				v_img[r][k] = random ? rand_pix() : val;
			end
		end
	endtask

	task automatic check_image(input string name);
		csc_pkg::rgb_pair_t exp;
		csc_pkg::mem_word_t act;
		int p;
		for (int r = 0; r < ROWS; r++) begin
			for (int k = 0; k < HALF; k++) begin
				p = r * HALF + k;
				exp = expected_pair(r, k);
				u_mem.peek(csc_pkg::addr_t'(RGB_BASE + 3 * p), act);
				check_word($sformatf("%s pair %0d word0", name, p), exp.word0, act);
				u_mem.peek(csc_pkg::addr_t'(RGB_BASE + 3 * p + 1), act);
				check_word($sformatf("%s pair %0d word1", name, p), exp.word1, act);
				u_mem.peek(csc_pkg::addr_t'(RGB_BASE + 3 * p + 2), act);
				check_word($sformatf("%s pair %0d word2", name, p), exp.word2, act);
			end
		end
	endtask

	task automatic test_reset_state();
		csc_pkg::apb_rsp_t rsp;
		apb_read(csc_pkg::REG_STATUS, rsp);
		check_rsp("reset_state", make_rsp(32'h0, 1'b0), rsp);
		apb_read(csc_pkg::REG_PAIRS, rsp);
		check_rsp("reset_state", make_rsp(32'h0, 1'b0), rsp);
	endtask

	task automatic test_flat_image();
		logic [23:0] px;
		csc_pkg::mem_word_t act;
		px = pixel_rgb(128, 128, 128); // Every pixel is the same colour
		fill_image(1'b0, 8'd128);
		load_image();
		start_run("flat_image");
		wait_idle();
		for (int p = 0; p < PAIRS; p++) begin
			u_mem.peek(csc_pkg::addr_t'(RGB_BASE + 3 * p), act);
			check_word("flat_image", px[23:8], act);
			u_mem.peek(csc_pkg::addr_t'(RGB_BASE + 3 * p + 1), act);
			check_word("flat_image", {px[7:0], px[23:16]}, act);
			u_mem.peek(csc_pkg::addr_t'(RGB_BASE + 3 * p + 2), act);
			check_word("flat_image", px[15:0], act);
		end
	endtask

	task automatic test_random_image();
		fill_image(1'b1, 8'd0);
		y_img[0][0] = 8'd255; // Red saturates high
		v_img[0][0] = 8'd255;
		u_img[0][1] = 8'd255; // Steep step for filter overshoot
		u_img[0][2] = 8'd0;
		y_img[1][7] = 8'd0; // Blue clips at 0 on the right edge
		u_img[1][3] = 8'd0;
		load_image();
		start_run("random_image");
		wait_idle();
		check_image("random_image");
	endtask

	task automatic test_restart();
		csc_pkg::apb_rsp_t rsp;
		csc_pkg::csc_status_t st;
		read_status(st);
		check_status("restart", 2'b10, st); // {done, busy}
		apb_read(csc_pkg::REG_PAIRS, rsp);
		check_rsp("restart", make_rsp(32'(PAIRS), 1'b0), rsp);
		fill_image(1'b1, 8'd0);
		load_image();
		start_run("restart");
		read_status(st);
		check_status("restart", 2'b01, st);
		wait_idle();
		read_status(st);
		check_status("restart", 2'b10, st);
		check_image("restart");
	endtask

	task automatic test_busy_start_and_errors();
		csc_pkg::apb_rsp_t rsp;
		csc_pkg::csc_status_t st;
		load_image();
		start_run("busy_start");
		apb_write(csc_pkg::REG_CTRL, 32'h1, rsp); // Lands while busy
		check_rsp("busy_start", make_rsp(32'h0, 1'b0), rsp);
		wait_idle();
		apb_read(csc_pkg::REG_PAIRS, rsp);
		check_rsp("busy_start", make_rsp(32'(PAIRS), 1'b0), rsp);
		check_image("busy_start");
		apb_write(csc_pkg::REG_STATUS, 32'h3, rsp);
		check_rsp("status_write", make_rsp(32'h0, 1'b1), rsp);
		read_status(st);
		check_status("status_write", 2'b10, st);
		apb_read(8'h0c, rsp);
		rsp.prdata = '0; // Only the error matters on an unmapped address
		check_rsp("unmapped_read", make_rsp(32'h0, 1'b1), rsp);
	endtask

	initial begin
		lfsr = 32'h0e02d367;
		apb_req = '0;
		resetn = 1'b0;
		repeat (3) @(posedge CLOCK_50_I);
		#1;
		resetn = 1'b1;
		test_reset_state();
		test_flat_image();
		test_random_image();
		test_restart();
		test_busy_start_and_errors();
		$display("Result: PASSED");
		$finish;
	end

endmodule
